//--- design/cache_pkg.sv
// Data cache package with geometry, address layout, store types and port structs.
package cache_pkg;

    // --------------------
    // Geometry.
    localparam int ADDR_W       = 64;
    localparam int DATA_W       = 64;
    localparam int BLOCK_W      = 512;
    localparam int WORD_W       = 32;
    localparam int HALF_W       = 16;
    localparam int BYTE_W       = 8;
    localparam int MEM_ADDR_W   = 32;

    localparam int N_DWORDS     = BLOCK_W / DATA_W;
    localparam int N_WORDS      = BLOCK_W / WORD_W;
    localparam int N_HALVES     = BLOCK_W / HALF_W;
    localparam int N_BYTES      = BLOCK_W / BYTE_W;

    localparam int N_SETS       = 2;
    localparam int INDEX_W      = $clog2(N_SETS);
    localparam int N_WAYS       = 2;
    localparam int WAY_W        = $clog2(N_WAYS);

    localparam int BYTE_OFS_W   = $clog2(WORD_W / BYTE_W);
    localparam int WORD_OFS_W   = $clog2(N_WORDS);
    localparam int BLOCK_OFS_W  = WORD_OFS_W + BYTE_OFS_W;
    localparam int TAG_W        = ADDR_W - INDEX_W - BLOCK_OFS_W;

    // Tag bits that still fit in a memory-side address.
    localparam int VICTIM_TAG_W = MEM_ADDR_W - INDEX_W - BLOCK_OFS_W;

    // --------------------
    // Types.
    typedef enum logic [1:0] {
        ST_BYTE   = 2'b00,
        ST_HALF   = 2'b01,
        ST_WORD   = 2'b10,
        ST_DOUBLE = 2'b11
    } store_type_e;

    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [WORD_OFS_W-1:0] word_ofs;
        logic [BYTE_OFS_W-1:0] byte_ofs;
    } cache_addr_s;

    // One block, seen at each store granularity.
    typedef union packed {
        logic [N_DWORDS-1:0][DATA_W-1:0] dwords;
        logic [N_WORDS-1:0][WORD_W-1:0]  words;
        logic [N_HALVES-1:0][HALF_W-1:0] halves;
        logic [N_BYTES-1:0][BYTE_W-1:0]  bytes;
    } cache_block_u;

    typedef struct packed {
        cache_addr_s       addr;
        logic [DATA_W-1:0] wdata;
        store_type_e       stype;
    } cache_req_s;

    typedef struct packed {
        logic                  hit;
        logic                  misaligned;
        logic [DATA_W-1:0]     rdata;
        logic                  victim_dirty;
        logic [MEM_ADDR_W-1:0] victim_addr;
    } cache_rsp_s;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
        logic             dirty;
    } line_entry_s;

endpackage

//--- design/tag_store.sv
// Tag store holding tag, valid and dirty per line, with hit compare and victim address.
module tag_store (
    input  logic                                clk,
    input  logic                                arst,
    input  logic [cache_pkg::INDEX_W-1:0]       i_index,
    input  logic [cache_pkg::TAG_W-1:0]         i_tag,
    input  logic                                i_store,
    input  logic                                i_refill,
    input  logic [cache_pkg::WAY_W-1:0]         i_sel_way,
    input  logic [cache_pkg::WAY_W-1:0]         i_victim_way,
    output logic [cache_pkg::N_WAYS-1:0]        o_hit_way,
    output logic                                o_victim_dirty,
    output logic [cache_pkg::MEM_ADDR_W-1:0]    o_victim_addr
);

    cache_pkg::line_entry_s lines [cache_pkg::N_SETS][cache_pkg::N_WAYS];
    cache_pkg::line_entry_s victim;

    // --------------------
    // Hit compare.
    always_comb begin
        for (int w = 0; w < cache_pkg::N_WAYS; w++) begin
            o_hit_way[w] = lines[i_index][w].valid && (lines[i_index][w].tag == i_tag);
        end
    end

    // --------------------
    // Victim view.
    assign victim         = lines[i_index][i_victim_way];
    assign o_victim_dirty = victim.dirty;

    // Block-aligned address of the line that would be evicted.
    assign o_victim_addr = {
        victim.tag[cache_pkg::VICTIM_TAG_W-1:0],
        i_index,
        {cache_pkg::BLOCK_OFS_W{1'b0}}
    };

    // --------------------
    // Line state update.
    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            for (int s = 0; s < cache_pkg::N_SETS; s++) begin
                for (int w = 0; w < cache_pkg::N_WAYS; w++) begin
                    lines[s][w] <= '0;
                end
            end
        end
        else if (i_store) begin
            lines[i_index][i_sel_way].dirty <= 1'b1;
        end
        else if (i_refill) begin
            // Fresh line from memory is clean.
            lines[i_index][i_victim_way].tag   <= i_tag;
            lines[i_index][i_victim_way].valid <= 1'b1;
            lines[i_index][i_victim_way].dirty <= 1'b0;
        end
    end

endmodule

//--- design/lru_tracker.sv
// LRU tracker keeping one victim-way bit per set, updated on a touch.
module lru_tracker (
    input  logic                           clk,
    input  logic                           arst,
    input  logic [cache_pkg::INDEX_W-1:0]  i_index,
    input  logic                           i_touch,
    input  logic [cache_pkg::WAY_W-1:0]    i_sel_way,
    output logic [cache_pkg::WAY_W-1:0]    o_victim_way
);

    // Least recently used way of each set.
    logic [cache_pkg::WAY_W-1:0] lru_q [cache_pkg::N_SETS];

    assign o_victim_way = lru_q[i_index];

    // --------------------
    // Update on touch.
    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            for (int s = 0; s < cache_pkg::N_SETS; s++) begin
                lru_q[s] <= '0;
            end
        end
        else if (i_touch) begin
            // The other way becomes the victim.
            lru_q[i_index] <= ~i_sel_way;
        end
    end

endmodule

//--- design/data_array.sv
// Data array storing one block per set and way, with store and refill writes.
module data_array (
    input  logic                           clk,
    input  logic                           arst,
    input  logic [cache_pkg::INDEX_W-1:0]  i_index,
    input  logic [cache_pkg::WAY_W-1:0]    i_sel_way,
    input  logic [cache_pkg::WAY_W-1:0]    i_victim_way,
    input  logic                           i_store,
    input  logic                           i_refill,
    input  cache_pkg::cache_block_u        i_store_block,
    input  cache_pkg::cache_block_u        i_fill_block,
    output cache_pkg::cache_block_u        o_sel_block,
    output cache_pkg::cache_block_u        o_victim_block
);

    cache_pkg::cache_block_u blocks [cache_pkg::N_SETS][cache_pkg::N_WAYS];

    // --------------------
    // Block reads.
    assign o_sel_block    = blocks[i_index][i_sel_way];
    assign o_victim_block = blocks[i_index][i_victim_way];

    // --------------------
    // Block writes.
    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            for (int s = 0; s < cache_pkg::N_SETS; s++) begin
                for (int w = 0; w < cache_pkg::N_WAYS; w++) begin
                    blocks[s][w] <= '0;
                end
            end
        end
        else if (i_store) begin
            // Store wins over a refill in the same cycle.
            blocks[i_index][i_sel_way] <= i_store_block;
        end
        else if (i_refill) begin
            blocks[i_index][i_victim_way] <= i_fill_block;
        end
    end

endmodule

//--- design/lane_unit.sv
// Lane unit merging store data into a block, extracting the read window, checking alignment.
module lane_unit (
    input  cache_pkg::cache_req_s              i_req,
    input  cache_pkg::cache_block_u            i_old_block,
    output cache_pkg::cache_block_u            o_store_block,
    output logic [cache_pkg::DATA_W-1:0]       o_rdata,
    output logic                               o_misaligned
);

    logic [cache_pkg::WORD_OFS_W-1:0]   word_ofs;
    logic [cache_pkg::BYTE_OFS_W-1:0]   byte_ofs;

    // Lane positions for each store size.
    logic [$clog2(cache_pkg::N_BYTES)-1:0]  byte_idx;
    logic [$clog2(cache_pkg::N_HALVES)-1:0] half_idx;
    logic [$clog2(cache_pkg::N_DWORDS)-1:0] dword_idx;

    logic [cache_pkg::WORD_OFS_W-1:0]   next_ofs;
    logic [cache_pkg::WORD_W-1:0]       lo_word;
    logic [cache_pkg::WORD_W-1:0]       hi_word;

    logic half_ma;
    logic word_ma;
    logic dword_ma;

    assign word_ofs  = i_req.addr.word_ofs;
    assign byte_ofs  = i_req.addr.byte_ofs;

    assign byte_idx  = {word_ofs, byte_ofs};
    assign half_idx  = {word_ofs, byte_ofs[1]};
    assign dword_idx = word_ofs[cache_pkg::WORD_OFS_W-1:1];

    // --------------------
    // Store merge.
    always_comb begin
        o_store_block = i_old_block;
        case (i_req.stype)
            cache_pkg::ST_BYTE: begin
                o_store_block.bytes[byte_idx] = i_req.wdata[cache_pkg::BYTE_W-1:0];
            end
            cache_pkg::ST_HALF: begin
                o_store_block.halves[half_idx] = i_req.wdata[cache_pkg::HALF_W-1:0];
            end
            cache_pkg::ST_WORD: begin
                o_store_block.words[word_ofs] = i_req.wdata[cache_pkg::WORD_W-1:0];
            end
            cache_pkg::ST_DOUBLE: begin
                o_store_block.dwords[dword_idx] = i_req.wdata;
            end
        endcase
    end

    // --------------------
    // Read window.
    assign next_ofs = word_ofs + 1'b1;
    assign lo_word  = i_old_block.words[word_ofs];

    // Window runs off the block end at the last word.
    assign hi_word  = (word_ofs == cache_pkg::WORD_OFS_W'(cache_pkg::N_WORDS - 1))
                    ? '0
                    : i_old_block.words[next_ofs];

    assign o_rdata  = {hi_word, lo_word};

    // --------------------
    // Alignment check.
    assign half_ma  = byte_ofs[0];
    assign word_ma  = |byte_ofs;
    assign dword_ma = word_ma | word_ofs[0];

    always_comb begin
        case (i_req.stype)
            cache_pkg::ST_HALF:   o_misaligned = half_ma;
            cache_pkg::ST_WORD:   o_misaligned = word_ma;
            cache_pkg::ST_DOUBLE: o_misaligned = dword_ma;
            default:              o_misaligned = 1'b0;
        endcase
    end

endmodule

//--- design/data_cache.sv
// Two-way set-associative data cache top with hit select, store, refill and writeback view.
module data_cache (
    input  logic                       clk,
    input  logic                       arst,
    input  cache_pkg::cache_req_s      i_req,
    input  cache_pkg::cache_block_u    i_fill_block,
    input  logic                       i_store,
    input  logic                       i_refill,
    input  logic                       i_touch,
    output cache_pkg::cache_rsp_s      o_rsp,
    output cache_pkg::cache_block_u    o_victim_block
);

    cache_pkg::cache_addr_s                 addr;

    logic [cache_pkg::N_WAYS-1:0]           hit_way;
    logic                                   hit;
    logic [cache_pkg::WAY_W-1:0]            victim_way;
    logic [cache_pkg::WAY_W-1:0]            sel_way;

    logic                                   victim_dirty;
    logic [cache_pkg::MEM_ADDR_W-1:0]       victim_addr;

    cache_pkg::cache_block_u                sel_block;
    cache_pkg::cache_block_u                store_block;
    logic [cache_pkg::DATA_W-1:0]           rdata;
    logic                                   misaligned;

    assign addr = i_req.addr;

    // --------------------
    // Way selection.
    assign hit = |hit_way;

    // Lowest hitting way first, victim on a miss.
    always_comb begin
        if (hit_way[0]) begin
            sel_way = '0;
        end
        else if (hit_way[1]) begin
            sel_way = cache_pkg::WAY_W'(1);
        end
        else begin
            sel_way = victim_way;
        end
    end

    // --------------------
    // Submodules.
    tag_store u_tag_store (
        .clk            (clk),
        .arst           (arst),
        .i_index        (addr.index),
        .i_tag          (addr.tag),
        .i_store        (i_store),
        .i_refill       (i_refill),
        .i_sel_way      (sel_way),
        .i_victim_way   (victim_way),
        .o_hit_way      (hit_way),
        .o_victim_dirty (victim_dirty),
        .o_victim_addr  (victim_addr)
    );

    lru_tracker u_lru_tracker (
        .clk          (clk),
        .arst         (arst),
        .i_index      (addr.index),
        .i_touch      (i_touch),
        .i_sel_way    (sel_way),
        .o_victim_way (victim_way)
    );

    data_array u_data_array (
        .clk            (clk),
        .arst           (arst),
        .i_index        (addr.index),
        .i_sel_way      (sel_way),
        .i_victim_way   (victim_way),
        .i_store        (i_store),
        .i_refill       (i_refill),
        .i_store_block  (store_block),
        .i_fill_block   (i_fill_block),
        .o_sel_block    (sel_block),
        .o_victim_block (o_victim_block)
    );

    lane_unit u_lane_unit (
        .i_req         (i_req),
        .i_old_block   (sel_block),
        .o_store_block (store_block),
        .o_rdata       (rdata),
        .o_misaligned  (misaligned)
    );

    // --------------------
    // Response.
    assign o_rsp = '{
        hit:          hit,
        misaligned:   misaligned,
        rdata:        rdata,
        victim_dirty: victim_dirty,
        victim_addr:  victim_addr
    };

endmodule

//--- tests/cache_checker.sv
// Cache checker that samples the DUT response per row and compares it with the expected values.
module cache_checker (
    input  logic                       clk,
    input  cache_pkg::cache_rsp_s      i_rsp,
    input  cache_pkg::cache_block_u    i_victim_block,
    input  logic                       i_check,
    input  logic [8*12-1:0]            i_name,
    input  cache_pkg::cache_rsp_s      i_exp,
    input  logic                       i_chk_vblk,
    input  cache_pkg::cache_block_u    i_exp_vblk,
    output int                         o_errors,
    output int                         o_checks
);

    // Sample just before the next rising edge.
    localparam int SAMPLE_DLY = 36;

    initial begin
        o_errors = 0;
        o_checks = 0;
    end

    task automatic report_value(input string field, input logic [511:0] exp_v,
                                input logic [511:0] act_v);
        $display("[FAIL] %0s %0s expected %0h actual %0h", i_name, field, exp_v, act_v);
        o_errors = o_errors + 1;
    endtask

    // --------------------
    // Compare on each row.
    always @(posedge clk) begin
        #SAMPLE_DLY;
        if (i_check) begin
            o_checks = o_checks + 1;
            if (i_rsp.hit !== i_exp.hit) begin
                report_value("hit", i_exp.hit, i_rsp.hit);
            end
            if (i_rsp.misaligned !== i_exp.misaligned) begin
                report_value("misaligned", i_exp.misaligned, i_rsp.misaligned);
            end
            if (i_rsp.rdata !== i_exp.rdata) begin
                report_value("rdata", i_exp.rdata, i_rsp.rdata);
            end
            if (i_rsp.victim_dirty !== i_exp.victim_dirty) begin
                report_value("victim_dirty", i_exp.victim_dirty, i_rsp.victim_dirty);
            end
            if (i_rsp.victim_addr !== i_exp.victim_addr) begin
                report_value("victim_addr", i_exp.victim_addr, i_rsp.victim_addr);
            end
            if (i_chk_vblk && (i_victim_block !== i_exp_vblk)) begin
                report_value("victim_block", i_exp_vblk, i_victim_block);
            end
        end
    end

endmodule

//--- tests/cache_tb.sv
// Data cache testbench driving a table of strobes and requests through the DUT.
module cache_tb;

    typedef struct packed {
        logic [8*12-1:0]         name;
        logic [2:0]              strb;
        cache_pkg::cache_req_s   req;
        cache_pkg::cache_block_u fill;
        cache_pkg::cache_rsp_s   exp;
        logic                    chk_vblk;
        cache_pkg::cache_block_u vblk;
    } row_s;

    logic                    clk;
    logic                    arst;
    cache_pkg::cache_req_s   req;
    cache_pkg::cache_block_u fill_block;
    logic                    store;
    logic                    refill;
    logic                    touch;
    cache_pkg::cache_rsp_s   rsp;
    cache_pkg::cache_block_u victim_block;

    row_s                    rows [$];
    row_s                    cur;
    logic                    check_en;
    int                      errors;
    int                      checks;
    int                      cycles;
    int                      limit;
    cache_pkg::cache_block_u pa, pb, pc, a_mod;

    always #20 clk = ~clk;

    data_cache dut (
        .clk(clk), .arst(arst), .i_req(req), .i_fill_block(fill_block), .i_store(store),
        .i_refill(refill), .i_touch(touch), .o_rsp(rsp), .o_victim_block(victim_block)
    );

    cache_checker chk (
        .clk(clk), .i_rsp(rsp), .i_victim_block(victim_block), .i_check(check_en),
        .i_name(cur.name), .i_exp(cur.exp), .i_chk_vblk(cur.chk_vblk), .i_exp_vblk(cur.vblk),
        .o_errors(errors), .o_checks(checks)
    );

    // --------------------
    // Stimulus helpers.
    function automatic cache_pkg::cache_block_u pattern_block(input logic [7:0] seed);
        for (int w = 0; w < 16; w++) begin
            pattern_block.words[w] = {seed, 8'hC3, 4'(w), 4'(~w), 8'(w * 37)};
        end
    endfunction

    function automatic logic [63:0] window(input cache_pkg::cache_block_u blk, input int w);
        window[31:0]  = blk.words[w];
        window[63:32] = (w == 15) ? 32'h0 : blk.words[w + 1];
    endfunction

    function automatic cache_pkg::cache_req_s store_req(input logic [56:0] tag, input logic idx,
            input logic [3:0] w, input logic [1:0] b, input cache_pkg::store_type_e st,
            input logic [63:0] wd);
        store_req.addr  = '{tag: tag, index: idx, word_ofs: w, byte_ofs: b};
        store_req.wdata = wd;
        store_req.stype = st;
    endfunction

    function automatic cache_pkg::cache_req_s read_req(input logic [56:0] tag, input logic idx,
            input logic [3:0] w);
        read_req = store_req(tag, idx, w, 2'd0, cache_pkg::ST_BYTE, 64'h0);
    endfunction

    function automatic cache_pkg::cache_rsp_s resp(input logic h, input logic ma,
            input logic [63:0] rd, input logic vd, input logic [31:0] va);
        resp = '{hit: h, misaligned: ma, rdata: rd, victim_dirty: vd, victim_addr: va};
    endfunction

    task automatic add_row(input logic [8*12-1:0] name, input logic [2:0] strb,
            input cache_pkg::cache_req_s rq, input cache_pkg::cache_block_u fb,
            input cache_pkg::cache_rsp_s ex, input logic cv, input cache_pkg::cache_block_u vb);
        rows.push_back('{name: name, strb: strb, req: rq, fill: fb, exp: ex, chk_vblk: cv, vblk: vb});
    endtask

    task automatic build_table();
        // Misaligned flags indexed by stype * 4 + byte_ofs.
        logic [15:0] ma_bits;
        ma_bits = 16'hEEA0;
        add_row("rst_miss0", 3'b000, read_req(5, 0, 0), '0, resp(0, 0, 0, 0, 'h0), 0, '0);
        add_row("rst_miss1", 3'b000, read_req(9, 1, 3), '0, resp(0, 0, 0, 0, 'h40), 0, '0);
        add_row("refill_a", 3'b010, read_req(5, 0, 0), pa, resp(0, 0, 0, 0, 'h0), 0, '0);
        add_row("touch_a", 3'b001, read_req(5, 0, 0), '0, resp(1, 0, window(pa, 0), 0, 'h280), 0, '0);
        add_row("read_a_w7", 3'b000, read_req(5, 0, 7), '0, resp(1, 0, window(pa, 7), 0, 'h0), 0, '0);
        add_row("read_a_w15", 3'b000, read_req(5, 0, 15), '0, resp(1, 0, window(pa, 15), 0, 'h0), 0, '0);
        add_row("st_byte", 3'b100, store_req(5, 0, 2, 1, cache_pkg::ST_BYTE, 64'hFFFF_FFFF_FFFF_FFEE),
                '0, resp(1, 0, window(pa, 2), 0, 'h0), 0, '0);
        add_row("rd_byte", 3'b000, read_req(5, 0, 2), '0, resp(1, 0, window(a_mod, 2), 0, 'h0), 0, '0);
        add_row("st_half", 3'b100, store_req(5, 0, 4, 2, cache_pkg::ST_HALF, 64'hFFFF_FFFF_FFFF_1234),
                '0, resp(1, 0, window(pa, 4), 0, 'h0), 0, '0);
        add_row("rd_half", 3'b000, read_req(5, 0, 4), '0, resp(1, 0, window(a_mod, 4), 0, 'h0), 0, '0);
        add_row("st_word", 3'b100, store_req(5, 0, 6, 0, cache_pkg::ST_WORD, 64'hFFFF_FFFF_DEAD_BEEF),
                '0, resp(1, 0, window(pa, 6), 0, 'h0), 0, '0);
        add_row("rd_word", 3'b000, read_req(5, 0, 6), '0, resp(1, 0, window(a_mod, 6), 0, 'h0), 0, '0);
        add_row("st_dbl", 3'b100, store_req(5, 0, 8, 0, cache_pkg::ST_DOUBLE, 64'h0123_4567_89AB_CDEF),
                '0, resp(1, 0, window(pa, 8), 0, 'h0), 0, '0);
        add_row("rd_dbl", 3'b000, read_req(5, 0, 8), '0, resp(1, 0, 64'h0123_4567_89AB_CDEF, 0, 'h0),
                0, '0);
        add_row("miss_b", 3'b000, read_req(9, 0, 0), '0, resp(0, 0, 0, 0, 'h0), 0, '0);
        add_row("refill_b", 3'b010, read_req(9, 0, 0), pb, resp(0, 0, 0, 0, 'h0), 0, '0);
        add_row("touch_b", 3'b001, read_req(9, 0, 0), '0, resp(1, 0, window(pb, 0), 0, 'h480), 1, pb);
        add_row("victim_a", 3'b000, read_req(9, 0, 0), '0, resp(1, 0, window(pb, 0), 1, 'h280), 1, a_mod);
        for (int t = 0; t < 4; t++) begin
            for (int b = 0; b < 4; b++) begin
                add_row("misalign", 3'b000, store_req(9, 0, 0, 2'(b), cache_pkg::store_type_e'(t), 0),
                        '0, resp(1, ma_bits[t * 4 + b], window(pb, 0), 1, 'h280), 0, '0);
            end
        end
        add_row("misalign_w1", 3'b000, store_req(9, 0, 1, 0, cache_pkg::ST_DOUBLE, 0), '0,
                resp(1, 1, window(pb, 1), 1, 'h280), 0, '0);
        add_row("refill_c", 3'b010, read_req(7, 1, 5), pc, resp(0, 0, 0, 0, 'h40), 0, '0);
        add_row("read_c", 3'b000, read_req(7, 1, 5), '0, resp(1, 0, window(pc, 5), 0, 'h3C0), 1, pc);
        add_row("recheck_a", 3'b000, read_req(5, 0, 6), '0, resp(1, 0, window(a_mod, 6), 1, 'h280),
                1, a_mod);
        add_row("recheck_b", 3'b000, read_req(9, 0, 8), '0, resp(1, 0, window(pb, 8), 1, 'h280),
                1, a_mod);
    endtask

    // --------------------
    // Timeout.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout after %0d cycles, the row loop did not finish.", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // --------------------
    // Main sequence.
    initial begin
        clk        = 0;
        arst       = 1;
        req        = '0;
        fill_block = '0;
        store      = 0;
        refill     = 0;
        touch      = 0;
        check_en   = 0;
        cur        = '0;
        cycles     = 0;
        limit      = 0;
        pa = pattern_block(8'hA1);
        pb = pattern_block(8'hB2);
        pc = pattern_block(8'hC3);
        a_mod = pa;
        a_mod.bytes[9]  = 8'hEE;
        a_mod.halves[9] = 16'h1234;
        a_mod.words[6]  = 32'hDEAD_BEEF;
        a_mod.dwords[4] = 64'h0123_4567_89AB_CDEF;
        build_table();
        limit = rows.size() + 2 + 20;
        repeat (2) @(posedge clk);
        #2 arst = 0;
        foreach (rows[i]) begin
            @(posedge clk);
            #2;
            cur = rows[i];
            {store, refill, touch} = cur.strb;
            req = cur.req;
            fill_block = cur.fill;
            check_en = 1;
        end
        @(posedge clk);
        #2;
        {store, refill, touch} = 3'b000;
        check_en = 0;
        repeat (2) @(posedge clk);
        $display("Rows checked: %0d, value errors: %0d", checks, errors);
        if (errors == 0 && checks == rows.size()) begin
            $display(">>> PASS");
        end
        else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
design/cache_pkg.sv
design/tag_store.sv
design/lru_tracker.sv
design/data_array.sv
design/lane_unit.sv
design/data_cache.sv
tests/cache_checker.sv
tests/cache_tb.sv
